/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = tb_cdc_acc
FILELIST  = vlog.f
SIM_ARGS  = +verilator+error+limit+100
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* acc_checker.sv */
`timescale 1ns/100ps

module acc_checker (
    input  logic                        rclk,
    input  logic                        rrstn,
    input  logic                        res_stb,
    input  logic [fifo_pkg::DATA_W-1:0] res_data,
    input  logic [7:0]                  drop_cnt,
    output int                          err_cnt,
    output int                          test_cnt
);

    // Expected result tagged with its test number
    typedef struct packed {
        logic [7:0]                  test;
        logic [fifo_pkg::DATA_W-1:0] value;
    } exp_t;

    exp_t exp_q[$];
    int   res_errs = 0;
    int   chk_errs = 0;
    int   errs_seen = 0;
    int   tests_done = 0;

    assign err_cnt  = res_errs + chk_errs;
    assign test_cnt = tests_done;

    function automatic string test_name(input int t);
        case (t)
            1: return "load_emit";
            2: return "arith";
            3: return "order";
            4: return "overflow";
            5: return "reset_state";
            default: return "unknown";
        endcase
    endfunction

    function automatic bit mismatch(input int t, input string what,
                                    input logic [7:0] want, input logic [7:0] got);
        if (got !== want) begin
            $display("CHECK FAILED %s %s expected %02h actual %02h",
                     test_name(t), what, want, got);
        end
        return got !== want;
    endfunction

    // Results must come back in command order
    always @(posedge rclk) begin
        exp_t e;
        if (rrstn && (res_stb === 1'b1)) begin
            if (exp_q.size() == 0) begin
                $display("Result %02h arrived while no result was expected", res_data);
                res_errs++;
            end else begin
                e = exp_q.pop_front();
                if (mismatch(int'(e.test), "res_data", e.value, res_data)) begin
                    res_errs++;
                end
            end
        end
    end

    task automatic expect_result(input int t, input logic [7:0] value);
        exp_t e;
        e.test  = t[7:0];
        e.value = value;
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Rise of drop_cnt since the start of the test
    task automatic check_drops(input int t, input logic [7:0] want, input logic [7:0] base);
        if (mismatch(t, "drop_cnt rise", want, drop_cnt - base)) begin
            chk_errs++;
        end
    endtask

    task automatic end_test(input int t);
        $display("Test %0d %s finished with %0d errors", t, test_name(t), err_cnt - errs_seen);
        errs_seen = err_cnt;
        tests_done++;
    endtask

endmodule

/* acc_engine.sv */
`timescale 1ns/100ps

module acc_engine (
    input  logic                        rclk,
    input  logic                        rrstn,
    input  logic                        hold,
    input  logic                        rempty,
    input  fifo_pkg::cmd_t              rd_word,
    output logic                        rd_stb,
    output logic                        res_stb,
    output logic [fifo_pkg::DATA_W-1:0] res_data
);

    // Word from the RAM read port is valid this cycle
    logic                        rd_pend;
    logic [fifo_pkg::DATA_W-1:0] acc;

    // Pop stage
    assign rd_stb = !rempty && !hold;

    // Execute stage, one cycle behind the pop
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rd_pend <= 1'b0;
            acc     <= '0;
            res_stb <= 1'b0;
        end else begin
            rd_pend <= rd_stb;
            res_stb <= 1'b0;
            if (rd_pend) begin
                unique case (rd_word.op)
                    fifo_pkg::OP_LOAD: acc <= rd_word.operand;
                    // Wraps modulo 2**DATA_W
                    fifo_pkg::OP_ADD:  acc <= acc + rd_word.operand;
                    fifo_pkg::OP_XOR:  acc <= acc ^ rd_word.operand;
                    fifo_pkg::OP_EMIT: res_stb <= 1'b1;
                    default:           acc <= acc;
                endcase
            end
        end
    end

    // Result carries the accumulator as it was before EMIT
    always_ff @(posedge rclk) begin
        if (rd_pend && (rd_word.op == fifo_pkg::OP_EMIT)) begin
            res_data <= acc;
        end
    end

endmodule

/* acc_patterns.txt */
// test kind op value hold, one record per line, all hex
// kind 00 command, 01 expected result, 02 expected drop_cnt rise, 0f end
01 01 00 5a 00
01 00 00 5a 00
01 00 03 00 00
02 01 00 39 00
02 00 00 10 00
02 00 01 f5 00
02 00 02 3c 00
02 00 03 00 00
03 01 00 01 00
03 01 00 03 00
03 01 00 fc 00
03 00 00 01 00
03 00 03 00 00
03 00 01 02 00
03 00 03 00 00
03 00 02 ff 00
03 00 03 00 00
04 01 00 9d 00
04 02 00 04 00
04 00 00 00 01
04 00 01 01 01
04 00 01 01 01
04 00 01 01 01
04 00 01 01 01
04 00 01 01 01
04 00 01 01 01
04 00 01 01 01
04 00 02 30 01
04 00 01 11 01
04 00 01 11 01
04 00 01 11 01
04 00 01 11 01
04 00 01 11 01
04 00 01 11 01
04 00 03 00 01
04 00 03 00 01
04 00 00 ff 01
04 00 03 00 01
04 00 01 01 01
00 0f 00 00 00

/* async_fifo.sv */
`timescale 1ns/100ps

module async_fifo (
    input  logic           wclk,
    input  logic           wrstn,
    input  logic           wr_stb,
    input  fifo_pkg::cmd_t wr_word,
    output logic           wfull,
    input  logic           rclk,
    input  logic           rrstn,
    input  logic           rd_stb,
    output logic           rempty,
    output fifo_pkg::cmd_t rd_word
);

    // Write domain pointers
    logic [fifo_pkg::PTR_W-1:0] wbin;
    logic [fifo_pkg::PTR_W-1:0] wbin_next;
    logic [fifo_pkg::PTR_W-1:0] wgray;

    // Read domain pointers
    logic [fifo_pkg::PTR_W-1:0] rbin;
    logic [fifo_pkg::PTR_W-1:0] rbin_next;
    logic [fifo_pkg::PTR_W-1:0] rgray;

    // Read pointer seen from the write side
    logic [fifo_pkg::PTR_W-1:0] rgray_s1;
    logic [fifo_pkg::PTR_W-1:0] rgray_s2;

    // Write pointer seen from the read side
    logic [fifo_pkg::PTR_W-1:0] wgray_s1;
    logic [fifo_pkg::PTR_W-1:0] wgray_s2;

    function automatic logic [fifo_pkg::PTR_W-1:0] bin2gray(
        input logic [fifo_pkg::PTR_W-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

    dual_port_ram dual_port_ram_i (
        .wclk  (wclk),
        .we    (wr_stb),
        .waddr (wbin[fifo_pkg::ADDR_W-1:0]),
        .wdata (wr_word),
        .rclk  (rclk),
        .re    (rd_stb),
        .raddr (rbin[fifo_pkg::ADDR_W-1:0]),
        .rdata (rd_word)
    );

    // The producer only strobes while not full
    assign wbin_next = wbin + fifo_pkg::PTR_W'(wr_stb);

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin  <= '0;
            wgray <= '0;
        end else begin
            wbin  <= wbin_next;
            wgray <= bin2gray(wbin_next);
        end
    end

    // The consumer only strobes while not empty
    assign rbin_next = rbin + fifo_pkg::PTR_W'(rd_stb);

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbin_next;
            rgray <= bin2gray(rbin_next);
        end
    end

    // Two-flop synchronizer into wclk
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            rgray_s1 <= '0;
            rgray_s2 <= '0;
        end else begin
            rgray_s1 <= rgray;
            rgray_s2 <= rgray_s1;
        end
    end

    // Two-flop synchronizer into rclk
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            wgray_s1 <= '0;
            wgray_s2 <= '0;
        end else begin
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
        end
    end

    // Full when the write side is one lap ahead
    assign wfull = (wgray == {~rgray_s2[fifo_pkg::PTR_W-1 -: 2],
                              rgray_s2[fifo_pkg::PTR_W-3:0]});
    assign rempty = (rgray == wgray_s2);

endmodule

/* async_fifo_properties.sv */
`timescale 1ns/100ps

module async_fifo_properties (
    input logic                       wclk,
    input logic                       wrstn,
    input logic                       wr_stb,
    input logic                       wfull,
    input logic [fifo_pkg::PTR_W-1:0] wbin,
    input logic [fifo_pkg::PTR_W-1:0] rgray_s2,
    input logic                       rclk,
    input logic                       rrstn,
    input logic                       rd_stb,
    input logic                       rempty,
    input logic [fifo_pkg::PTR_W-1:0] rbin,
    input logic [fifo_pkg::PTR_W-1:0] wgray_s2
);

    localparam int P = fifo_pkg::PTR_W;

    // Assertion failure counts per clock domain
    int wr_fails = 0;
    int rd_fails = 0;

    // Fill level as each side sees it through its synchronizer
    logic [P-1:0] wfill;
    logic [P-1:0] rfill;

    function automatic logic [P-1:0] gray2bin(input logic [P-1:0] gray);
        logic [P-1:0] bin;
        bin[P-1] = gray[P-1];
        for (int i = P - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    assign wfill = wbin - gray2bin(rgray_s2);
    assign rfill = gray2bin(wgray_s2) - rbin;

    no_write_when_full: assert property (
        @(posedge wclk) disable iff (!wrstn) !(wr_stb && wfull)
    ) else begin
        $error("write strobe while the FIFO is full");
        wr_fails++;
    end

    no_read_when_empty: assert property (
        @(posedge rclk) disable iff (!rrstn) !(rd_stb && rempty)
    ) else begin
        $error("read strobe while the FIFO is empty");
        rd_fails++;
    end

    // A level past FIFO_DEPTH would make full look like empty
    wr_level_in_range: assert property (
        @(posedge wclk) disable iff (!wrstn) wfill <= fifo_pkg::FIFO_DEPTH
    ) else begin
        $error("write side sees more entries than the FIFO holds");
        wr_fails++;
    end

    rd_level_in_range: assert property (
        @(posedge rclk) disable iff (!rrstn) rfill <= fifo_pkg::FIFO_DEPTH
    ) else begin
        $error("read side sees more entries than the FIFO holds");
        rd_fails++;
    end

endmodule

bind async_fifo async_fifo_properties async_fifo_properties_i (.*);

/* cdc_acc_top.sv */
`timescale 1ns/100ps

module cdc_acc_top (
    input  logic                        wclk,
    input  logic                        wrstn,
    input  logic                        cmd_stb,
    input  fifo_pkg::cmd_t              cmd,
    output logic [7:0]                  drop_cnt,
    input  logic                        rclk,
    input  logic                        rrstn,
    input  logic                        hold,
    output logic                        res_stb,
    output logic [fifo_pkg::DATA_W-1:0] res_data
);

    // Producer to FIFO
    logic           wr_stb;
    fifo_pkg::cmd_t wr_word;
    logic           wfull;

    // FIFO to consumer
    logic           rd_stb;
    logic           rempty;
    fifo_pkg::cmd_t rd_word;

    cmd_framer cmd_framer_i (
        .wclk     (wclk),
        .wrstn    (wrstn),
        .cmd_stb  (cmd_stb),
        .cmd      (cmd),
        .wfull    (wfull),
        .wr_stb   (wr_stb),
        .wr_word  (wr_word),
        .drop_cnt (drop_cnt)
    );

    async_fifo async_fifo_i (
        .wclk    (wclk),
        .wrstn   (wrstn),
        .wr_stb  (wr_stb),
        .wr_word (wr_word),
        .wfull   (wfull),
        .rclk    (rclk),
        .rrstn   (rrstn),
        .rd_stb  (rd_stb),
        .rempty  (rempty),
        .rd_word (rd_word)
    );

    acc_engine acc_engine_i (
        .rclk     (rclk),
        .rrstn    (rrstn),
        .hold     (hold),
        .rempty   (rempty),
        .rd_word  (rd_word),
        .rd_stb   (rd_stb),
        .res_stb  (res_stb),
        .res_data (res_data)
    );

endmodule

/* cmd_framer.sv */
`timescale 1ns/100ps

module cmd_framer (
    input  logic           wclk,
    input  logic           wrstn,
    input  logic           cmd_stb,
    input  fifo_pkg::cmd_t cmd,
    input  logic           wfull,
    output logic           wr_stb,
    output fifo_pkg::cmd_t wr_word,
    output logic [7:0]     drop_cnt
);

    // Command refused because the FIFO is full
    logic drop;

    // Accept in the same cycle when there is room
    assign wr_stb  = cmd_stb && !wfull;
    assign wr_word = cmd;

    assign drop = cmd_stb && wfull;

    // Drop counter holds at its maximum
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            drop_cnt <= '0;
        end else if (drop && (drop_cnt != 8'hff)) begin
            drop_cnt <= drop_cnt + 8'd1;
        end
    end

endmodule

/* dual_port_ram.sv */
`timescale 1ns/100ps

module dual_port_ram (
    input  logic                        wclk,
    input  logic                        we,
    input  logic [fifo_pkg::ADDR_W-1:0] waddr,
    input  fifo_pkg::cmd_t              wdata,
    input  logic                        rclk,
    input  logic                        re,
    input  logic [fifo_pkg::ADDR_W-1:0] raddr,
    output fifo_pkg::cmd_t              rdata
);

    // Storage array, no reset
    logic [fifo_pkg::CMD_W-1:0] mem [fifo_pkg::FIFO_DEPTH];

    // Write port in the wclk domain
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port, data valid one rclk after re
    always_ff @(posedge rclk) begin
        if (re) begin
            rdata <= fifo_pkg::cmd_t'(mem[raddr]);
        end
    end

endmodule

/* fifo_pkg.sv */
package fifo_pkg;

    // Operand and accumulator width
    localparam int DATA_W = 8;

    // FIFO geometry
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    // Extra wrap bit tells full from empty
    localparam int PTR_W = ADDR_W + 1;

    // Opcode field plus operand
    localparam int CMD_W = 2 + DATA_W;

    // Accumulator opcodes
    typedef enum logic [1:0] {
        OP_LOAD = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2,
        OP_EMIT = 2'd3
    } acc_op_e;

    // One command word as it crosses the FIFO
    typedef struct packed {
        acc_op_e            op;
        logic [DATA_W-1:0]  operand;
    } cmd_t;

endpackage

/* tb_cdc_acc.sv */
`timescale 1ns/100ps

module tb_cdc_acc;

    // Record kinds in the pattern file
    localparam logic [7:0] KIND_CMD  = 8'h00;
    localparam logic [7:0] KIND_RES  = 8'h01;
    localparam logic [7:0] KIND_DROP = 8'h02;
    localparam int         RES_TIMEOUT = 400;

    logic                        wclk = 1'b0;
    logic                        wrstn = 1'b0;
    logic                        rclk = 1'b0;
    logic                        rrstn = 1'b0;
    logic                        cmd_stb = 1'b0;
    fifo_pkg::cmd_t              cmd = '0;
    logic                        hold = 1'b0;
    logic [7:0]                  drop_cnt;
    logic                        res_stb;
    logic [fifo_pkg::DATA_W-1:0] res_data;
    int                          err_cnt;
    int                          test_cnt;
    integer                      seed = 32'ha962;
    bit                          timed_out = 1'b0;
    // Five bytes per record
    logic [7:0]                  pat [320];

    always #7 wclk = ~wclk;
    always #5 rclk = ~rclk;

    cdc_acc_top cdc_acc_top_i (.*);

    acc_checker acc_checker_i (.*);

    // One command strobe, then 0 to 3 idle wclk cycles
    task automatic send_cmd(input logic [7:0] op, input logic [7:0] operand);
        int idle;
        @(posedge wclk);
        #1;
        cmd_stb     = 1'b1;
        cmd.op      = fifo_pkg::acc_op_e'(op[1:0]);
        cmd.operand = operand;
        @(posedge wclk);
        #1;
        cmd_stb = 1'b0;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge wclk);
    endtask

    // Check drops, release hold and wait for every pending result
    task automatic finish_test(input int t, input bit drop_chk, input logic [7:0] drop_want,
                               input logic [7:0] drop_base);
        int cycles;
        @(posedge wclk);
        #1;
        if (drop_chk) begin
            acc_checker_i.check_drops(t, drop_want, drop_base);
        end
        @(posedge rclk);
        #1;
        hold = 1'b0;
        cycles = 0;
        while ((acc_checker_i.pending() != 0) && (cycles < RES_TIMEOUT)) begin
            @(posedge rclk);
            #1;
            cycles++;
        end
        if (acc_checker_i.pending() != 0) begin
            $display("Timeout in test %0d, %0d results never arrived", t,
                     acc_checker_i.pending());
            timed_out = 1'b1;
        end else begin
            // Stray strobes from dropped commands show up here
            repeat (8) @(posedge rclk);
            acc_checker_i.end_test(t);
        end
    endtask

    initial begin
        int         idx;
        int         cur;
        bit         drop_chk;
        logic [7:0] drop_want;
        logic [7:0] drop_base;
        int         fails;
        $readmemh("acc_patterns.txt", pat);
        fork
            begin
                repeat (3) @(posedge wclk);
                #1;
                wrstn = 1'b1;
            end
            begin
                repeat (3) @(posedge rclk);
                #1;
                rrstn = 1'b1;
            end
        join
        // Idle after reset, no strobe and no drops allowed
        repeat (10) @(posedge rclk);
        #1;
        acc_checker_i.check_drops(5, 8'h00, 8'h00);
        acc_checker_i.end_test(5);
        idx       = 0;
        cur       = int'(pat[0]);
        drop_chk  = 1'b0;
        drop_want = 8'h00;
        drop_base = drop_cnt;
        while (!timed_out && (idx + 4 < $size(pat))) begin
            if ((pat[idx+1] > KIND_DROP) || (int'(pat[idx]) != cur)) begin
                finish_test(cur, drop_chk, drop_want, drop_base);
                cur       = int'(pat[idx]);
                drop_chk  = 1'b0;
                drop_base = drop_cnt;
            end
            case (pat[idx+1])
                KIND_CMD: begin
                    if (pat[idx+4][0] !== hold) begin
                        @(posedge rclk);
                        #1;
                        hold = pat[idx+4][0];
                    end
                    send_cmd(pat[idx+2], pat[idx+3]);
                end
                KIND_RES: acc_checker_i.expect_result(cur, pat[idx+3]);
                KIND_DROP: begin
                    drop_chk  = 1'b1;
                    drop_want = pat[idx+3];
                end
                // End record
                default: idx = $size(pat);
            endcase
            idx += 5;
        end
        fails = cdc_acc_top_i.async_fifo_i.async_fifo_properties_i.wr_fails
              + cdc_acc_top_i.async_fifo_i.async_fifo_properties_i.rd_fails;
        $display("Tests %0d, check errors %0d, assertion failures %0d, timeouts %0d",
                 test_cnt, err_cnt, fails, timed_out);
        if (!timed_out && (err_cnt == 0) && (fails == 0)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
fifo_pkg.sv
dual_port_ram.sv
async_fifo.sv
cmd_framer.sv
acc_engine.sv
cdc_acc_top.sv
async_fifo_properties.sv
acc_checker.sv
tb_cdc_acc.sv
